/* project.f */
+incdir+tb
source/subCpuPkg.sv
source/cpuAddressDecoder.sv
source/frameSupervisor.sv
source/subCpuGlue.sv
tb/subCpuGlueTb.sv

/* Bender.yml */
package:
  name: sub_cpu_glue

sources:
  - source/subCpuPkg.sv
  - source/cpuAddressDecoder.sv
  - source/frameSupervisor.sv
  - source/subCpuGlue.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/subCpuGlueTb.sv

/* tb/subCpuGlueModel.svh */
`ifndef SUB_CPU_GLUE_MODEL_SVH
`define SUB_CPU_GLUE_MODEL_SVH

////////////////////////////////////////
// Expected supervisor state
////////////////////////////////////////

wdCount_t expCount;
logic expNRes;
logic expNIrq;

// Inclusive range test on the full 16-bit address
function automatic logic between(input logic [15:0] a, input logic [15:0] lo,
	input logic [15:0] hi);
	return (a >= lo) && (a <= hi);
endfunction

// Memory map as seen from the CPU, low address bits taken as zero
function automatic chipSelects_t expectedSelects(input cpuBus_t b);
	logic [15:0] a;
	logic rd;
	chipSelects_t s;
	a = {b.addr, 10'h000};
	rd = b.rnw;
	s.nScr0 = ~between(a, 16'h0000, 16'h1FFF);
	s.nScr1 = ~between(a, 16'h2000, 16'h3FFF);
	s.nObj = ~between(a, 16'h4000, 16'h5FFF);
	s.nSnd = ~between(a, 16'h4000, 16'h43FF);
	s.nSpgm = ~(rd & between(a, 16'h6000, 16'h7FFF));
	s.nMpgm = ~(rd & between(a, 16'h8000, 16'hFFFF));
	s.bank = ~rd & between(a, 16'h8800, 16'h8FFF);
	s.nLth0 = ~(~rd & between(a, 16'h9000, 16'h93FF));
	s.nLth1 = ~(~rd & between(a, 16'h9400, 16'h97FF));
	s.nLth2 = ~(~rd & between(a, 16'hA000, 16'hA3FF));
	// Buffer opens when any of its six sources is selected
	s.nBufEn = ~(~s.nScr0 | ~s.nScr1 | ~s.nObj | ~s.nSnd | ~s.nLth0 | ~s.nLth1);
	return s;
endfunction

// State right after reset
function automatic void resetModel();
	expCount = '0;
	expNRes = 1'b1;
	expNIrq = 1'b1;
endfunction

// One vBlank edge, b is the bus held during the frame before it
function automatic void stepSupervisor(input cpuBus_t b);
	logic [15:0] a;
	logic kick;
	logic ack;
	a = {b.addr, 10'h000};
	kick = ~b.rnw & between(a, 16'h8000, 16'h83FF);
	ack = ~b.rnw & between(a, 16'h8400, 16'h87FF);
	if (kick || (expCount == wdTerminal)) begin
		expCount = '0;
	end else begin
		expCount = expCount + 1'b1;
	end
	expNRes = ~expCount[wdWidth-1];
	expNIrq = ~ack;
endfunction

`endif

/* tb/subCpuGlueTb.sv */
`default_nettype none

module subCpuGlueTb import subCpuPkg::*; ();

	localparam int clkPeriod = 8;
	localparam int rowCount = 30;
	localparam int randomFrames = 200;

	logic nVBLK;
	logic rst;
	cpuBus_t bus;
	chipSelects_t sel;
	logic nRes;
	logic nIrq;

	// Bus value that the next edge will sample
	cpuBus_t appliedBus;
	int errorCount;
	int checkCount;

	// Stimulus table
	string rowName [rowCount];
	cpuBus_t rowBus [rowCount];
	chipSelects_t rowSel [rowCount];
	int rowFill;

	`include "subCpuGlueModel.svh"

	subCpuGlue u_dut (
		.nVBLK(nVBLK),
		.rst(rst),
		.bus(bus),
		.sel(sel),
		.nRes(nRes),
		.nIrq(nIrq)
	);

	// Frame clock
	initial begin
		nVBLK = 1'b0;
		forever #(clkPeriod / 2) nVBLK = ~nVBLK;
	end

	// Run limit from the number of frames
	initial begin
		#((rowCount + randomFrames + 40) * clkPeriod);
		$display("Timeout: the run did not finish in the expected number of frames");
		$display("Test failures found");
		$finish;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic addRow(input string name, input addrHigh_t addr, input logic rnw,
		input logic [10:0] expSel);
		rowName[rowFill] = name;
		rowBus[rowFill] = {addr, rnw};
		rowSel[rowFill] = expSel;
		rowFill++;
	endtask

	task automatic checkValue(input string name, input string what,
		input logic [10:0] expVal, input logic [10:0] actVal);
		checkCount++;
		assert (actVal === expVal) else begin
			errorCount++;
			$display("MISMATCH %s %s: expected %h, actual %h", name, what, expVal, actVal);
		end
	endtask

	// Drive one frame, then check once everything has settled
	task automatic runFrame(input string name, input cpuBus_t b, input chipSelects_t expSel);
		@(posedge nVBLK);
		stepSupervisor(appliedBus);
		bus <= b;
		appliedBus = b;
		@(negedge nVBLK);
		checkValue(name, "sel", expSel, sel);
		checkValue(name, "nRes", expNRes, nRes);
		checkValue(name, "nIrq", expNIrq, nIrq);
	endtask

	// Select bits from the top down nScr0 nScr1 nObj nSnd nSpgm nMpgm nLth0 nLth1 nLth2
	// nBufEn bank
	// First twelve rows hold no kick so the watchdog runs free through a wrap
	task automatic fillTable();
		addRow("scr0 first rd", 6'h00, 1'b1, 11'h3FC);
		addRow("scr0 last wr", 6'h07, 1'b0, 11'h3FC);
		addRow("scr1 first rd", 6'h08, 1'b1, 11'h5FC);
		addRow("scr1 last wr", 6'h0F, 1'b0, 11'h5FC);
		addRow("obj snd rd", 6'h10, 1'b1, 11'h67C);
		addRow("obj last wr", 6'h17, 1'b0, 11'h6FC);
		addRow("spgm first rd", 6'h18, 1'b1, 11'h7BE);
		addRow("spgm last rd", 6'h1F, 1'b1, 11'h7BE);
		addRow("spgm wr", 6'h1F, 1'b0, 11'h7FE);
		addRow("mpgm first rd", 6'h20, 1'b1, 11'h7DE);
		addRow("mpgm last rd", 6'h3F, 1'b1, 11'h7DE);
		addRow("bank first wr", 6'h22, 1'b0, 11'h7FF);
		// Kicks every few frames from here on
		addRow("kick wr", 6'h20, 1'b0, 11'h7FE);
		addRow("bank last wr", 6'h23, 1'b0, 11'h7FF);
		addRow("bank rd", 6'h22, 1'b1, 11'h7DE);
		addRow("ack wr", 6'h21, 1'b0, 11'h7FE);
		addRow("lth0 wr", 6'h24, 1'b0, 11'h7EC);
		addRow("lth0 rd", 6'h24, 1'b1, 11'h7DE);
		addRow("lth1 wr", 6'h25, 1'b0, 11'h7F4);
		addRow("kick wr 2", 6'h20, 1'b0, 11'h7FE);
		// Back colour latch leaves the buffer closed
		addRow("lth2 wr", 6'h28, 1'b0, 11'h7FA);
		addRow("ack wr 2", 6'h21, 1'b0, 11'h7FE);
		addRow("ack wr 3", 6'h21, 1'b0, 11'h7FE);
		addRow("kick wr 3", 6'h20, 1'b0, 11'h7FE);
		addRow("obj snd wr", 6'h10, 1'b0, 11'h67C);
		// Reads of the write-only registers only open the program EPROM
		addRow("kick rd", 6'h20, 1'b1, 11'h7DE);
		addRow("ack rd", 6'h21, 1'b1, 11'h7DE);
		addRow("lth1 rd", 6'h25, 1'b1, 11'h7DE);
		addRow("lth2 rd", 6'h28, 1'b1, 11'h7DE);
		addRow("mpgm last wr", 6'h3F, 1'b0, 11'h7FE);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin : mainSequence
		logic [31:0] rnd;
		cpuBus_t randBus;
		void'($urandom(27));
		errorCount = 0;
		checkCount = 0;
		rowFill = 0;
		rst = 1'b1;
		bus = {6'h1F, 1'b0};
		appliedBus = {6'h1F, 1'b0};
		fillTable();

		repeat (10) @(posedge nVBLK);
		rst <= 1'b0;
		resetModel();
		@(negedge nVBLK);
		checkValue("reset", "nRes", 1'b1, nRes);
		checkValue("reset", "nIrq", 1'b1, nIrq);

		for (int i = 0; i < rowCount; i++) begin
			runFrame(rowName[i], rowBus[i], rowSel[i]);
		end

		// Random traffic, rare kicks let the watchdog wrap
		for (int i = 0; i < randomFrames; i++) begin
			rnd = $urandom();
			randBus = rnd[6:0];
			runFrame($sformatf("random %0d", i), randBus, expectedSelects(randBus));
		end

		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/subCpuGlue.sv */
`default_nettype none

module subCpuGlue import subCpuPkg::*; (
	input logic nVBLK,
	input logic rst,
	input cpuBus_t bus,
	output chipSelects_t sel,
	output logic nRes,
	output logic nIrq
);

	////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////

	// Kick and acknowledge decodes into the frame block
	frameStrobes_t strobes;

	////////////////////////////////////////
	// Memory map decode
	////////////////////////////////////////

	// Purely combinational, selects leave the top in the same cycle
	cpuAddressDecoder u_decoder (
		.bus(bus),
		.sel(sel),
		.strobes(strobes)
	);

	////////////////////////////////////////
	// Frame rate supervisor
	////////////////////////////////////////

	// Watchdog and interrupt level, updated once per vertical blank
	frameSupervisor u_supervisor (
		.nVBLK(nVBLK),
		.rst(rst),
		.strobes(strobes),
		.nRes(nRes),
		.nIrq(nIrq)
	);

endmodule

`default_nettype wire

/* source/frameSupervisor.sv */
`default_nettype none

module frameSupervisor import subCpuPkg::*; (
	input logic nVBLK,
	input logic rst,
	input frameStrobes_t strobes,
	output logic nRes,
	output logic nIrq
);

	////////////////////////////////////////
	// Watchdog counter
	////////////////////////////////////////

	// Frames since the last kick or wrap
	wdCount_t wdCount;

	// Terminal count reached this frame
	logic wdWrap;

	// Counter goes back to zero on the next edge
	logic wdClear;

	assign wdWrap = (wdCount == wdTerminal);

	// A kick from the CPU restarts the count
	assign wdClear = strobes.wdKick | wdWrap;

	// One count per vertical blank
	always_ff @(posedge nVBLK) begin
		if (rst) begin
			wdCount <= '0;
		end else if (wdClear) begin
			wdCount <= '0;
		end else begin
			wdCount <= wdCount + wdCount_t'(1);
		end
	end

	// Board reset follows the top bit
	// Low from count 8 up to the wrap, so a stalled CPU sits in reset a few frames
	assign nRes = ~wdCount[wdWidth-1];

	////////////////////////////////////////
	// Interrupt request
	////////////////////////////////////////

	// Request asserts every frame unless the CPU acknowledged at this edge
	always_ff @(posedge nVBLK) begin
		if (rst) begin
			nIrq <= 1'b1;
		end else begin
			nIrq <= ~strobes.irqAck;
		end
	end

endmodule

`default_nettype wire

/* source/cpuAddressDecoder.sv */
`default_nettype none

module cpuAddressDecoder import subCpuPkg::*; (
	input cpuBus_t bus,
	output chipSelects_t sel,
	output frameStrobes_t strobes
);

	////////////////////////////////////////
	// Block match helper
	////////////////////////////////////////

	// True when the block lies inside the range, ends included
	function automatic logic inRange(input addrHigh_t blk, input addrRange_t range);
		return (blk >= range.first) && (blk <= range.last);
	endfunction

	// Direction levels
	logic isRead;
	logic isWrite;

	// Raw region hits, before direction qualification
	logic hitScr0;
	logic hitScr1;
	logic hitObj;
	logic hitSnd;
	logic hitSpgm;
	logic hitMpgm;
	logic hitKick;
	logic hitAck;
	logic hitBank;
	logic hitLth0;
	logic hitLth1;
	logic hitLth2;

	assign isRead = bus.rnw;
	assign isWrite = ~bus.rnw;

	////////////////////////////////////////
	// Region compare
	////////////////////////////////////////

	// Video RAM 1 at 0000h to 1FFFh
	assign hitScr0 = inRange(bus.addr, scr0Range);

	// Video RAM 2 at 2000h to 3FFFh
	assign hitScr1 = inRange(bus.addr, scr1Range);

	// Sprite RAM at 4000h to 5FFFh
	assign hitObj = inRange(bus.addr, objRange);

	// Sound CPU shared RAM, first block of the sprite window
	assign hitSnd = inRange(bus.addr, sndRange);

	// Sub program EPROM at 6000h to 7FFFh
	assign hitSpgm = inRange(bus.addr, spgmRange);

	// Main program EPROM covers the whole upper half
	assign hitMpgm = inRange(bus.addr, mpgmRange);

	// Watchdog kick at 8000h
	assign hitKick = inRange(bus.addr, kickRange);

	// Interrupt acknowledge at 8400h
	assign hitAck = inRange(bus.addr, ackRange);

	// Tile bank select at 8800h to 8FFFh
	assign hitBank = inRange(bus.addr, bankRange);

	// Scroll and priority latches for planes 0 and 1
	assign hitLth0 = inRange(bus.addr, lth0Range);

	// Scroll and priority latches for planes 2 and 3
	assign hitLth1 = inRange(bus.addr, lth1Range);

	// Back colour latch at A000h
	assign hitLth2 = inRange(bus.addr, lth2Range);

	////////////////////////////////////////
	// Select outputs
	////////////////////////////////////////

	always_comb begin
		// RAM selects ignore direction
		sel.nScr0 = ~hitScr0;
		sel.nScr1 = ~hitScr1;
		sel.nObj = ~hitObj;
		// Overlaps the sprite select as on the board
		sel.nSnd = ~hitSnd;

		// EPROMs only answer reads
		sel.nSpgm = ~(isRead & hitSpgm);
		sel.nMpgm = ~(isRead & hitMpgm);

		// Latches and bank strobe only take writes
		sel.nLth0 = ~(isWrite & hitLth0);
		sel.nLth1 = ~(isWrite & hitLth1);
		sel.nLth2 = ~(isWrite & hitLth2);
		sel.bank = isWrite & hitBank;

		// Data buffer opens for RAM and the plane latches
		// Back colour latch sits on the near side of the buffer
		sel.nBufEn = sel.nScr0 & sel.nScr1 & sel.nObj & sel.nSnd
			& sel.nLth0 & sel.nLth1;
	end

	////////////////////////////////////////
	// Supervisor strobes
	////////////////////////////////////////

	// Both are write decodes held for as long as the bus holds the address
	assign strobes.wdKick = isWrite & hitKick;
	assign strobes.irqAck = isWrite & hitAck;

endmodule

`default_nettype wire

/* source/subCpuPkg.sv */
`default_nettype none

package subCpuPkg;

	////////////////////////////////////////
	// Widths and watchdog constants
	////////////////////////////////////////

	// CPU address bits 15 to 10, one value per 1 KB block
	typedef logic [5:0] addrHigh_t;

	// Watchdog counter width, after the decade counter on the board
	localparam int wdWidth = 4;

	// Frame count held by the watchdog
	typedef logic [wdWidth-1:0] wdCount_t;

	// Count at which the watchdog wraps back to zero
	localparam wdCount_t wdTerminal = wdCount_t'(10);

	////////////////////////////////////////
	// Bus and select bundles
	////////////////////////////////////////

	// Upper address lines and direction level, rnw high for a read
	typedef struct packed {
		addrHigh_t addr;
		logic rnw;
	} cpuBus_t;

	// Chip selects are active low, except the tile bank strobe
	typedef struct packed {
		logic nScr0;
		logic nScr1;
		logic nObj;
		logic nSnd;
		logic nSpgm;
		logic nMpgm;
		logic nLth0;
		logic nLth1;
		logic nLth2;
		logic nBufEn;
		logic bank;
	} chipSelects_t;

	// Write decodes sampled by the supervisor once per frame
	typedef struct packed {
		logic wdKick;
		logic irqAck;
	} frameStrobes_t;

	////////////////////////////////////////
	// Memory map in 1 KB blocks
	////////////////////////////////////////

	// First and last block of a decoded range, both inclusive
	typedef struct packed {
		addrHigh_t first;
		addrHigh_t last;
	} addrRange_t;

	// Video RAM 1 and 2, sprite RAM and the shared sound RAM window
	localparam addrRange_t scr0Range = '{first: 6'h00, last: 6'h07};
	localparam addrRange_t scr1Range = '{first: 6'h08, last: 6'h0F};
	localparam addrRange_t objRange = '{first: 6'h10, last: 6'h17};
	localparam addrRange_t sndRange = '{first: 6'h10, last: 6'h10};

	// Program EPROMs
	localparam addrRange_t spgmRange = '{first: 6'h18, last: 6'h1F};
	localparam addrRange_t mpgmRange = '{first: 6'h20, last: 6'h3F};

	// Write-only registers in the upper half
	localparam addrRange_t kickRange = '{first: 6'h20, last: 6'h20};
	localparam addrRange_t ackRange = '{first: 6'h21, last: 6'h21};
	localparam addrRange_t bankRange = '{first: 6'h22, last: 6'h23};
	localparam addrRange_t lth0Range = '{first: 6'h24, last: 6'h24};
	localparam addrRange_t lth1Range = '{first: 6'h25, last: 6'h25};
	localparam addrRange_t lth2Range = '{first: 6'h28, last: 6'h28};

endpackage

`default_nettype wire
